//--- hdl/cpr_pkg.sv
package cpr_pkg;

    // Download index of a CPR image
    localparam logic [7:0] CPR_INDEX = 8'd5;

    // ROM and block geometry
    localparam int ROM_ADDR_W  = 23;
    localparam int BLOCK_BITS  = 14;
    localparam int BLOCK_NUM_W = 5;
    localparam int unsigned BLOCK_BYTES = 1 << BLOCK_BITS;   // 16 KiB
    localparam int ADDR_PAD_W  = ROM_ADDR_W - BLOCK_NUM_W - BLOCK_BITS;

    // Tags, first stream byte in the top bits
    localparam logic [31:0] RIFF_TAG  = "RIFF";
    localparam logic [31:0] FORM_TAG  = "AMS!";
    localparam logic [31:0] FMT_TAG   = "fmt ";
    localparam logic [23:0] CB_PREFIX = "cb0";

    // Version, flags, load address and exec address bytes
    localparam int FMT_BYTES = 6;

    typedef enum logic [1:0] {
        kind_format,
        kind_block,
        kind_other
    } chunk_kind_t;

    typedef enum logic [2:0] {
        st_riff,
        st_riff_size,
        st_form,
        st_chunk_id,
        st_chunk_size,
        st_body
    } parse_state_t;

    // Download strobe bundle, 18 bits
    typedef struct packed {
        logic       download;
        logic       wr;
        logic [7:0] index;
        logic [7:0] dout;
    } load_port_t;

    // One classified chunk body byte, 48 bits
    typedef struct packed {
        logic                   valid;
        chunk_kind_t            kind;
        logic [BLOCK_NUM_W-1:0] block;
        logic [31:0]            offset;
        logic [7:0]             data;
    } chunk_byte_t;

    // Fields of the fmt chunk, 48 bits
    typedef struct packed {
        logic [7:0]  version;
        logic [7:0]  flags;
        logic [15:0] load_addr;
        logic [15:0] exec_addr;
    } cpr_format_t;

endpackage

//--- hdl/riff_chunk_parser.sv
`timescale 1ns/1ps

module riff_chunk_parser import cpr_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  load_port_t  load,
    output chunk_byte_t body
);

    parse_state_t           state;
    logic [31:0]            shift;        // Tag or size being collected
    logic [1:0]             byte_cnt;     // Byte within tag or size
    chunk_kind_t            kind;
    logic [BLOCK_NUM_W-1:0] block;
    logic [31:0]            body_offset;

    logic        accept;
    logic        last_byte;
    logic [31:0] tag_word;
    logic [31:0] size_word;
    logic [7:0]  id_char;
    logic        is_digit;
    logic        is_letter;
    logic [7:0]  block_char_num;
    logic        is_block_id;

    // Only CPR strobes count
    assign accept = load.download && load.wr && (load.index == CPR_INDEX);
    assign last_byte = (byte_cnt == 2'd3);

    // Tags shift in from the bottom, sizes arrive little-endian
    assign tag_word  = {shift[23:0], load.dout};
    assign size_word = {load.dout, shift[31:8]};

    // Block letter of a "cb0X" id
    assign id_char   = tag_word[7:0];
    assign is_digit  = (id_char >= "0") && (id_char <= "9");
    assign is_letter = (id_char >= "A") && (id_char <= "V");
    assign block_char_num = is_digit ? (id_char - "0") : (id_char - "A" + 8'd10);
    assign is_block_id = (tag_word[31:8] == CB_PREFIX) && (is_digit || is_letter);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state       <= st_riff;
            byte_cnt    <= '0;
            body.valid  <= 1'b0;
        end else begin
            body.valid <= 1'b0;   // One pulse per body byte

            if (!load.download) begin
                // Aborted or finished download
                state    <= st_riff;
                byte_cnt <= '0;
            end else if (accept) begin
                case (state)
                    st_riff: begin
                        shift    <= tag_word;
                        byte_cnt <= byte_cnt + 2'd1;
                        if (last_byte && tag_word == RIFF_TAG) begin
                            state <= st_riff_size;
                        end
                    end

                    st_riff_size: begin
                        // File size is not needed
                        byte_cnt <= byte_cnt + 2'd1;
                        if (last_byte) begin
                            state <= st_form;
                        end
                    end

                    st_form: begin
                        shift    <= tag_word;
                        byte_cnt <= byte_cnt + 2'd1;
                        if (last_byte) begin
                            state <= (tag_word == FORM_TAG) ? st_chunk_id : st_riff;
                        end
                    end

                    st_chunk_id: begin
                        shift    <= tag_word;
                        byte_cnt <= byte_cnt + 2'd1;
                        if (last_byte) begin
                            state <= st_chunk_size;
                            block <= block_char_num[BLOCK_NUM_W-1:0];
                            if (tag_word == FMT_TAG) begin
                                kind <= kind_format;
                            end else if (is_block_id) begin
                                kind <= kind_block;
                            end else begin
                                kind <= kind_other;   // Skipped by size
                            end
                        end
                    end

                    st_chunk_size: begin
                        // Size stays in the shift register for the body
                        shift       <= size_word;
                        byte_cnt    <= byte_cnt + 2'd1;
                        body_offset <= '0;
                        if (last_byte) begin
                            state <= (size_word == 32'd0) ? st_chunk_id : st_body;
                        end
                    end

                    st_body: begin
                        body.valid  <= 1'b1;
                        body.kind   <= kind;
                        body.block  <= block;
                        body.offset <= body_offset;
                        body.data   <= load.dout;
                        body_offset <= body_offset + 32'd1;
                        if (body_offset + 32'd1 == shift) begin
                            state <= st_chunk_id;   // Next chunk header
                        end
                    end

                    default: begin
                        state    <= st_riff;
                        byte_cnt <= '0;
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/cpr_block_writer.sv
`timescale 1ns/1ps

module cpr_block_writer import cpr_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  chunk_byte_t           body,
    output logic [ROM_ADDR_W-1:0] rom_addr,
    output logic [7:0]            rom_data,
    output logic                  rom_wr
);

    logic in_block;
    logic write_hit;
    logic [ROM_ADDR_W-1:0] byte_addr;

    // Bytes past 16 KiB are dropped here
    assign in_block  = (body.offset < BLOCK_BYTES);
    assign write_hit = body.valid && (body.kind == kind_block) && in_block;

    // Block number on top of the offset inside the block
    assign byte_addr = {{ADDR_PAD_W{1'b0}}, body.block, body.offset[BLOCK_BITS-1:0]};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rom_wr <= 1'b0;
        end else begin
            rom_wr <= write_hit;
        end
    end

    // Address and data only move on a write
    always_ff @(posedge clk_sys) begin
        if (write_hit) begin
            rom_addr <= byte_addr;
            rom_data <= body.data;
        end
    end

endmodule

//--- hdl/cpr_format_decoder.sv
`timescale 1ns/1ps

module cpr_format_decoder import cpr_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  chunk_byte_t body,
    output cpr_format_t format,
    output logic        auto_boot,
    output logic [15:0] boot_addr
);

    logic        fmt_hit;
    logic [15:0] exec_word;

    // Only the leading fields of the fmt chunk matter
    assign fmt_hit   = body.valid && (body.kind == kind_format) && (body.offset < FMT_BYTES);
    assign exec_word = {body.data, format.exec_addr[7:0]};   // Valid at the last field

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            format    <= '0;
            auto_boot <= 1'b0;
            boot_addr <= '0;
        end else if (fmt_hit) begin
            case (body.offset[2:0])
                3'd0: format.version         <= body.data;
                3'd1: format.flags           <= body.data;
                3'd2: format.load_addr[7:0]  <= body.data;
                3'd3: format.load_addr[15:8] <= body.data;
                3'd4: format.exec_addr[7:0]  <= body.data;
                3'd5: begin
                    format.exec_addr[15:8] <= body.data;
                    // Zero exec address means no auto-boot
                    if (exec_word != 16'h0000) begin
                        auto_boot <= 1'b1;
                        boot_addr <= exec_word;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/cpr_loader_top.sv
`timescale 1ns/1ps

module cpr_loader_top import cpr_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  load_port_t            load,
    output logic [ROM_ADDR_W-1:0] rom_addr,
    output logic [7:0]            rom_data,
    output logic                  rom_wr,
    output cpr_format_t           format,
    output logic                  auto_boot,
    output logic [15:0]           boot_addr
);

    chunk_byte_t body;   // Shared by both consumers

    riff_chunk_parser u_parser (
        .clk_sys (clk_sys),
        .reset   (reset),
        .load    (load),
        .body    (body)
    );

    // ROM writes for cb0X chunks
    cpr_block_writer u_block_writer (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .body     (body),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_wr   (rom_wr)
    );

    // Boot fields from the fmt chunk
    cpr_format_decoder u_format_decoder (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .body      (body),
        .format    (format),
        .auto_boot (auto_boot),
        .boot_addr (boot_addr)
    );

endmodule

//--- tb/cpr_loader_properties.sv
`timescale 1ns/1ps

module cpr_loader_properties import cpr_pkg::*; (
    input logic                  clk_sys,
    input logic                  reset,
    input logic                  rom_wr,
    input logic [ROM_ADDR_W-1:0] rom_addr,
    input logic                  auto_boot,
    input logic [15:0]           boot_addr
);

    int fail_count = 0;   // Read by the testbench top at the end

    rom_wr_low_after_reset: assert property (@(posedge clk_sys) reset |=> !rom_wr)
        else begin
            $error("rom_wr high in the cycle after reset");
            fail_count++;
        end

    // Auto-boot only ever arms with a real address
    boot_addr_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
        auto_boot |-> (boot_addr != 16'h0000))
        else begin
            $error("auto_boot set with a zero boot_addr");
            fail_count++;
        end

    write_addr_known: assert property (@(posedge clk_sys) disable iff (reset)
        rom_wr |-> !$isunknown(rom_addr))
        else begin
            $error("rom_addr unknown during a ROM write");
            fail_count++;
        end

endmodule

bind cpr_loader_top cpr_loader_properties props (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .rom_wr    (rom_wr),
    .rom_addr  (rom_addr),
    .auto_boot (auto_boot),
    .boot_addr (boot_addr)
);

//--- tb/cpr_loader_checker.sv
`timescale 1ns/1ps

module cpr_loader_checker import cpr_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  load_port_t            load,
    input  logic [ROM_ADDR_W-1:0] rom_addr,
    input  logic [7:0]            rom_data,
    input  logic                  rom_wr,
    input  cpr_format_t           format,
    input  logic                  auto_boot,
    input  logic [15:0]           boot_addr,
    input  logic                  check_end,
    output int                    errors
);

    // Model of the CPR stream
    parse_state_t m_state;
    int           m_count;    // Header bytes collected
    logic [31:0]  m_word;     // Tag, first byte on top
    logic [31:0]  m_size;     // Little-endian chunk size
    logic [31:0]  m_id;
    logic [31:0]  m_offset;
    cpr_format_t  m_format;
    logic         m_boot;
    logic [15:0]  m_boot_addr;

    logic [ROM_ADDR_W+7:0] expected_q[$];   // {addr, data}
    logic [ROM_ADDR_W+7:0] head;
    logic [ROM_ADDR_W-1:0] exp_addr;
    logic                  hit;
    int                    err_count = 0;

    assign errors = err_count;

    // Block number of a cb0X id, -1 for anything else
    function automatic int block_number(input logic [31:0] id);
        logic [7:0] c;
        c = id[7:0];
        if (id[31:8] != CB_PREFIX) begin
            return -1;
        end
        if (c >= "0" && c <= "9") begin
            return int'(c) - 48;
        end
        if (c >= "A" && c <= "V") begin
            return int'(c) - 65 + 10;
        end
        return -1;
    endfunction

    function void store_format(input logic [31:0] off, input logic [7:0] b);
        case (off)
            0: m_format.version = b;
            1: m_format.flags = b;
            2: m_format.load_addr[7:0] = b;
            3: m_format.load_addr[15:8] = b;
            4: m_format.exec_addr[7:0] = b;
            5: begin
                m_format.exec_addr[15:8] = b;
                if (m_format.exec_addr != 16'h0000) begin
                    m_boot = 1'b1;
                    m_boot_addr = m_format.exec_addr;
                end
            end
            default: ;
        endcase
    endfunction

    // Reference: steps the model by one accepted byte, returns 1 on an expected write
    function logic expect_byte(input logic [7:0] b, output logic [ROM_ADDR_W-1:0] addr);
        int blk;
        expect_byte = 1'b0;
        addr = '0;
        if (m_state != st_body) begin
            if (m_count == 0) begin
                m_size = '0;
            end
            m_word = {m_word[23:0], b};
            m_size = m_size | (32'(b) << (8 * m_count));
            m_count = m_count + 1;
            if (m_count == 4) begin
                m_count = 0;
                case (m_state)
                    st_riff: m_state = (m_word == RIFF_TAG) ? st_riff_size : st_riff;
                    st_riff_size: m_state = st_form;
                    st_form: m_state = (m_word == FORM_TAG) ? st_chunk_id : st_riff;
                    st_chunk_id: begin
                        m_id = m_word;
                        m_state = st_chunk_size;
                    end
                    st_chunk_size: begin
                        m_offset = '0;
                        m_state = (m_size == 32'd0) ? st_chunk_id : st_body;
                    end
                    default: m_state = st_riff;
                endcase
            end
        end else begin
            blk = block_number(m_id);
            if (m_id == FMT_TAG) begin
                store_format(m_offset, b);
            end else if (blk >= 0 && m_offset < 32'd16384) begin
                expect_byte = 1'b1;
                addr = ROM_ADDR_W'(blk * 16384 + int'(m_offset));
            end
            m_offset = m_offset + 32'd1;
            if (m_offset == m_size) begin
                m_state = st_chunk_id;
            end
        end
    endfunction

    task model_reset();
        m_state = st_riff;
        m_count = 0;
        m_word = '0;
        m_size = '0;
        m_id = '0;
        m_offset = '0;
        m_format = '0;
        m_boot = 1'b0;
        m_boot_addr = '0;
        expected_q.delete();
    endtask

    task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %0h actual %0h", $time, name, expected,
                     actual);
            err_count++;
        end
    endtask

    task end_of_test_checks();
        if (expected_q.size() != 0) begin
            $display("%0d expected ROM writes never arrived by %0t ns", expected_q.size(), $time);
            err_count++;
            expected_q.delete();
        end
        check_value("auto_boot", 32'(m_boot), 32'(auto_boot));
        check_value("boot_addr", 32'(m_boot_addr), 32'(boot_addr));
        check_value("format.version", 32'(m_format.version), 32'(format.version));
        check_value("format.flags", 32'(m_format.flags), 32'(format.flags));
        check_value("format.load_addr", 32'(m_format.load_addr), 32'(format.load_addr));
        check_value("format.exec_addr", 32'(m_format.exec_addr), 32'(format.exec_addr));
    endtask

    always @(posedge clk_sys) begin
        if (reset) begin
            model_reset();
        end else begin
            if (rom_wr) begin
                if (expected_q.size() == 0) begin
                    $display("ROM write to %06h at %0t ns with no write expected", rom_addr,
                             $time);
                    err_count++;
                end else begin
                    head = expected_q.pop_front();
                    check_value("rom_addr", 32'(head[ROM_ADDR_W+7:8]), 32'(rom_addr));
                    check_value("rom_data", 32'(head[7:0]), 32'(rom_data));
                end
            end
            if (!load.download) begin
                m_state = st_riff;   // Download ended
                m_count = 0;
            end else if (load.wr && load.index == CPR_INDEX) begin
                hit = expect_byte(load.dout, exp_addr);
                if (hit) begin
                    expected_q.push_back({exp_addr, load.dout});
                end
            end
            if (check_end) begin
                end_of_test_checks();
            end
        end
    end

endmodule

//--- tb/tb_cpr_loader.sv
`timescale 1ns/1ps

module tb_cpr_loader import cpr_pkg::*; ();

    localparam logic [15:0] SEED = 16'd56192;
    localparam int BLK_LEN   = 64;
    localparam int SHORT_LEN = 32;
    localparam int LONG_LEN  = 16400;   // Runs past the end of a block
    localparam int JUNK_LEN  = 20;
    localparam int TINY_LEN  = 16;
    // 9 file headers, 16 chunk headers and all bodies
    localparam int TOTAL_BYTES = 9 * 12 + 16 * 8 + 2 * FMT_BYTES + 2 * BLK_LEN
                               + 7 * SHORT_LEN + LONG_LEN + JUNK_LEN + 2 * TINY_LEN;
    localparam int GAP_MAX = 3;
    localparam int CYCLE_LIMIT = 2 * TOTAL_BYTES + GAP_MAX * TOTAL_BYTES + 1000;

    logic                  clk_sys = 1'b0;
    logic                  reset;
    load_port_t            load;
    logic [ROM_ADDR_W-1:0] rom_addr;
    logic [7:0]            rom_data;
    logic                  rom_wr;
    cpr_format_t           format;
    logic                  auto_boot;
    logic [15:0]           boot_addr;
    logic                  check_end;
    int                    errors;

    logic [7:0]  img[$];   // Image being built
    logic [15:0] lfsr;
    int          cycles = 0;
    int          n_pass;
    int          n_fail;
    int          err_before;

    always #50 clk_sys = ~clk_sys;

    cpr_loader_top DUT (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .load      (load),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_wr    (rom_wr),
        .format    (format),
        .auto_boot (auto_boot),
        .boot_addr (boot_addr)
    );

    cpr_loader_checker checker_inst (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .load      (load),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_wr    (rom_wr),
        .format    (format),
        .auto_boot (auto_boot),
        .boot_addr (boot_addr),
        .check_end (check_end),
        .errors    (errors)
    );

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task take_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task put_tag(input logic [31:0] tag);
        img.push_back(tag[31:24]);   // Stream order
        img.push_back(tag[23:16]);
        img.push_back(tag[15:8]);
        img.push_back(tag[7:0]);
    endtask

    task put_size(input logic [31:0] size);
        img.push_back(size[7:0]);
        img.push_back(size[15:8]);
        img.push_back(size[23:16]);
        img.push_back(size[31:24]);
    endtask

    task put_chunk_header(input logic [31:0] id, input int size);
        put_tag(id);
        put_size(32'(size));
    endtask

    task put_header(input logic [31:0] riff, input logic [31:0] form);
        img.delete();
        put_tag(riff);
        put_size(32'd4);   // File size, ignored by the loader
        put_tag(form);
    endtask

    task put_random(input int n);
        logic [15:0] v;
        int i;
        for (i = 0; i < n; i++) begin
            take_bits(8, v);
            img.push_back(v[7:0]);
        end
    endtask

    task put_fmt(input logic [7:0] version, input logic [7:0] flags,
                 input logic [15:0] load_addr, input logic [15:0] exec_addr);
        put_chunk_header(FMT_TAG, FMT_BYTES);
        img.push_back(version);
        img.push_back(flags);
        img.push_back(load_addr[7:0]);
        img.push_back(load_addr[15:8]);
        img.push_back(exec_addr[7:0]);
        img.push_back(exec_addr[15:8]);
    endtask

    // First count bytes of the image, random idle gaps before each strobe
    task send_image(input logic [7:0] idx, input int count);
        logic [15:0] gap;
        int i;
        for (i = 0; i < count; i++) begin
            take_bits(2, gap);
            repeat (gap[1:0]) begin
                @(posedge clk_sys);
                load.wr <= 1'b0;
            end
            @(posedge clk_sys);
            load.download <= 1'b1;
            load.wr       <= 1'b1;
            load.index    <= idx;
            load.dout     <= img[i];
        end
        @(posedge clk_sys);
        load.wr <= 1'b0;
    endtask

    task end_download();
        @(posedge clk_sys);
        load.download <= 1'b0;
        load.wr       <= 1'b0;
        @(posedge clk_sys);
    endtask

    task start_test();
        @(posedge clk_sys);
        reset <= 1'b1;
        repeat (3) @(posedge clk_sys);
        reset <= 1'b0;
        err_before = errors;
    endtask

    task finish_test(input int num, input string name);
        end_download();
        repeat (3) @(posedge clk_sys);   // Past the two-cycle write latency
        check_end <= 1'b1;
        @(posedge clk_sys);
        check_end <= 1'b0;
        @(posedge clk_sys);
        if (errors == err_before) begin
            n_pass++;
            $display("test %0d, %s: ok", num, name);
        end else begin
            n_fail++;
            $display("test %0d, %s: %0d errors", num, name, errors - err_before);
        end
    endtask

    initial begin
        reset = 1'b1;
        load = '0;
        check_end = 1'b0;
        lfsr = SEED;
        n_pass = 0;
        n_fail = 0;

        start_test();
        put_header(RIFF_TAG, FORM_TAG);
        put_fmt(8'h01, 8'h03, 16'h1234, 16'h0150);
        put_chunk_header("cb00", BLK_LEN);
        put_random(BLK_LEN);
        put_chunk_header("cb01", BLK_LEN);
        put_random(BLK_LEN);
        send_image(CPR_INDEX, img.size());
        finish_test(1, "fmt chunk with blocks cb00 and cb01");

        start_test();
        put_header(RIFF_TAG, FORM_TAG);
        put_chunk_header("cb0C", SHORT_LEN);
        put_random(SHORT_LEN);
        put_chunk_header("cb0V", SHORT_LEN);
        put_random(SHORT_LEN);
        put_chunk_header("cb03", LONG_LEN);
        put_random(LONG_LEN);
        send_image(CPR_INDEX, img.size());
        finish_test(2, "letter blocks and an oversized block");

        start_test();
        put_header(RIFF_TAG, FORM_TAG);
        put_chunk_header("cb02", SHORT_LEN);
        put_random(SHORT_LEN);
        put_chunk_header("junk", JUNK_LEN);
        put_random(JUNK_LEN);
        put_chunk_header("cb05", 0);
        put_chunk_header("cb04", SHORT_LEN);
        put_random(SHORT_LEN);
        send_image(CPR_INDEX, img.size());
        finish_test(3, "unknown and empty chunks skipped");

        start_test();
        put_header("RIFX", FORM_TAG);
        put_chunk_header("cb08", TINY_LEN);
        put_random(TINY_LEN);
        send_image(CPR_INDEX, img.size());
        end_download();
        put_header(RIFF_TAG, "AMS?");
        put_chunk_header("cb09", TINY_LEN);
        put_random(TINY_LEN);
        send_image(CPR_INDEX, img.size());
        end_download();
        put_header(RIFF_TAG, FORM_TAG);
        put_fmt(8'h02, 8'h00, 16'h8000, 16'h0000);
        send_image(CPR_INDEX, img.size());
        finish_test(4, "bad tags and a zero exec address");

        start_test();
        put_header(RIFF_TAG, FORM_TAG);
        put_chunk_header("cb06", SHORT_LEN);
        put_random(SHORT_LEN);
        send_image(8'd4, img.size());   // Other download index
        send_image(CPR_INDEX, 12 + 8 + 10);
        end_download();
        put_header(RIFF_TAG, FORM_TAG);
        put_chunk_header("cb07", SHORT_LEN);
        put_random(SHORT_LEN);
        send_image(CPR_INDEX, img.size());
        finish_test(5, "wrong index and a dropped download");

        $display("summary: %0d tests ok, %0d failing, %0d assertion failures", n_pass, n_fail,
                 DUT.props.fail_count);
        if (n_fail == 0 && DUT.props.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
hdl/cpr_pkg.sv
hdl/riff_chunk_parser.sv
hdl/cpr_block_writer.sv
hdl/cpr_format_decoder.sv
hdl/cpr_loader_top.sv
tb/cpr_loader_properties.sv
tb/cpr_loader_checker.sv
tb/tb_cpr_loader.sv

//--- Makefile
TOP := tb_cpr_loader

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build folder"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
